/* common/fetch_pkg.sv */
package fetch_pkg;

    // byte address, virtual before translation and physical after
    typedef logic [31:0] vaddr_t;

    // CP0 cause code
    typedef logic [4:0] exc_code_t;

    localparam exc_code_t EXC_NONE = 5'd0;
    // TLB refill or invalid page on fetch
    localparam exc_code_t EXC_TLBL = 5'd2;
    // misaligned fetch address
    localparam exc_code_t EXC_ADEL = 5'd4;

    // boot ROM entry
    localparam vaddr_t RESET_PC = 32'hbfc0_0000;
    // general exception handler
    localparam vaddr_t GENERAL_EX_PC = 32'hbfc0_0380;
    // TLB refill handler
    localparam vaddr_t REFILL_EX_PC = 32'hbfc0_0200;

    // icache set index, address bits 11..4
    typedef logic [7:0] cache_index_t;

    // byte offset inside a 16-byte line
    typedef logic [3:0] cache_offset_t;

endpackage

/* common/tlb_pkg.sv */
package tlb_pkg;

    // virtual page number, address bits 31..12
    typedef logic [19:0] vpn_t;

    // physical frame number
    typedef logic [19:0] pfn_t;

    // EntryLo C field
    typedef logic [2:0] cache_attr_t;

    // instruction TLB buffer refill FSM
    typedef enum logic {
        ITLB_READY,
        ITLB_WAIT
    } itlb_state_t;

endpackage

/* common/br_if.sv */
`timescale 1ns/1ps

// resolved branch from the execute stage
interface br_if;

    // prediction was made for this branch
    logic             bpu_checked;
    logic             is_branch;
    logic             taken;
    // predictor got it right
    logic             bpu_right;
    fetch_pkg::vaddr_t target;
    fetch_pkg::vaddr_t es_pc;

    modport source (
        output bpu_checked, is_branch, taken, bpu_right, target, es_pc
    );

    modport sink (
        input bpu_checked, is_branch, taken, bpu_right, target, es_pc
    );

endinterface

/* pre_if/itlb_stage.sv */
`timescale 1ns/1ps

module itlb_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  tlb_pkg::vpn_t        vpn,
    output tlb_pkg::vpn_t        tlb_vpn,
    input  logic                 tlb_found,
    input  tlb_pkg::pfn_t        tlb_pfn0,
    input  tlb_pkg::pfn_t        tlb_pfn1,
    input  tlb_pkg::cache_attr_t tlb_c0,
    input  tlb_pkg::cache_attr_t tlb_c1,
    input  logic                 tlb_d0,
    input  logic                 tlb_d1,
    input  logic                 tlb_v0,
    input  logic                 tlb_v1,
    input  logic                 tlb_buffer_flush,
    output tlb_pkg::pfn_t        pfn,
    output logic                 itlb_ex,
    output fetch_pkg::exc_code_t itlb_exc,
    output logic                 refill_miss,
    output logic                 itlb_stall
);

    tlb_pkg::itlb_state_t state;
    tlb_pkg::vpn_t        buf_vpn;
    tlb_pkg::pfn_t        sel_pfn;
    tlb_pkg::cache_attr_t sel_c;
    logic                 sel_d;
    logic                 sel_v;
    logic                 buf_valid;
    logic                 buf_found;
    logic                 buf_v;
    logic                 miss;

    // odd VPN bit picks the odd page of the pair
    assign sel_pfn = vpn[0] ? tlb_pfn1 : tlb_pfn0;
    assign sel_c   = vpn[0] ? tlb_c1 : tlb_c0;
    assign sel_d   = vpn[0] ? tlb_d1 : tlb_d0;
    assign sel_v   = vpn[0] ? tlb_v1 : tlb_v0;

    assign miss       = ~buf_valid | (vpn != buf_vpn);
    assign itlb_stall = (state == tlb_pkg::ITLB_WAIT) | miss;
    assign tlb_vpn    = vpn;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= tlb_pkg::ITLB_READY;
            buf_valid <= 1'b0;
        end else if (state == tlb_pkg::ITLB_WAIT) begin
            state     <= tlb_pkg::ITLB_READY;
            buf_valid <= ~tlb_buffer_flush;
        end else begin
            if (miss)
                state <= tlb_pkg::ITLB_WAIT;
            if (tlb_buffer_flush)
                buf_valid <= 1'b0;
        end
    end

    // entry payload captured on the answer cycle
    always_ff @(posedge clk) begin
        if (state == tlb_pkg::ITLB_WAIT) begin
            buf_vpn   <= vpn;
            pfn       <= sel_pfn;
            buf_found <= tlb_found;
            buf_v     <= sel_v;
        end
    end

    assign refill_miss = buf_valid & ~buf_found;
    assign itlb_ex     = buf_valid & ~(buf_found & buf_v);
    assign itlb_exc    = itlb_ex ? fetch_pkg::EXC_TLBL : fetch_pkg::EXC_NONE;

    // outside TLB must give a clean answer one cycle after the request
    a_answer_known: assert property (
        @(posedge clk) disable iff (reset)
        (state == tlb_pkg::ITLB_WAIT && tlb_found) |->
            !$isunknown({sel_pfn, sel_c, sel_d, sel_v})
    );

endmodule

/* pre_if/pre_if_stage.sv */
`timescale 1ns/1ps

module pre_if_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fs_allowin,
    br_if.sink                     br,
    input  logic                   bpu_valid,
    input  fetch_pkg::vaddr_t      bpu_target,
    input  logic                   br_flush,
    input  logic                   flush,
    input  logic                   flush_refill,
    input  logic                   eret,
    input  fetch_pkg::vaddr_t      epc,
    input  logic                   refetch,
    input  fetch_pkg::vaddr_t      refetch_pc,
    input  logic                   icache_inst,
    input  fetch_pkg::cache_index_t icache_inst_index,
    input  logic                   icache_busy,
    output tlb_pkg::vpn_t          itlb_vpn,
    input  tlb_pkg::pfn_t          itlb_pfn,
    input  logic                   itlb_ex,
    input  fetch_pkg::exc_code_t   itlb_exc,
    input  logic                   itlb_stall,
    output fetch_pkg::vaddr_t      pc,
    output logic                   ps_to_fs_valid,
    output logic                   inst_valid,
    output fetch_pkg::cache_index_t inst_index,
    output tlb_pkg::pfn_t          inst_tag,
    output fetch_pkg::cache_offset_t inst_offset,
    output logic                   ps_ex,
    output fetch_pkg::exc_code_t   ps_exc,
    output logic                   icache_inst_delayed
);

    fetch_pkg::vaddr_t       next_pc;
    fetch_pkg::vaddr_t       seq_pc;
    fetch_pkg::cache_index_t index_held;
    logic                    ready_go;
    logic                    pc_load;
    logic                    adel_ex;
    logic                    flush_delayed;
    logic                    refetch_delayed;

    assign ready_go       = ~icache_busy & ~itlb_stall;
    assign pc_load        = flush | (fs_allowin & ready_go);
    assign ps_to_fs_valid = ready_go;
    assign seq_pc         = pc + 32'd4;

    always_comb begin
        if (eret) begin
            next_pc = epc;
        end else if (flush) begin
            if (flush_refill)
                next_pc = fetch_pkg::REFILL_EX_PC;
            else if (refetch)
                next_pc = refetch_pc;
            else
                next_pc = fetch_pkg::GENERAL_EX_PC;
        end else if (br.is_branch && br.bpu_checked) begin
            // checked: keep the predicted path if right, repair it if wrong
            if (br.bpu_right)
                next_pc = bpu_valid ? bpu_target : seq_pc;
            else
                next_pc = br.taken ? br.target : br.es_pc + 32'd8;
        end else if (br.is_branch && br.taken) begin
            next_pc = br.target;
        end else begin
            next_pc = bpu_valid ? bpu_target : seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc <= fetch_pkg::RESET_PC;
        else if (pc_load)
            pc <= next_pc;
    end

    // AdEL has priority over a TLB fault
    assign adel_ex = pc[1:0] != 2'b00;
    assign ps_ex   = adel_ex | itlb_ex;
    assign ps_exc  = adel_ex ? fetch_pkg::EXC_ADEL :
                     itlb_ex ? itlb_exc : fetch_pkg::EXC_NONE;

    // hold these until the cache goes idle
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_delayed       <= 1'b0;
            refetch_delayed     <= 1'b0;
            icache_inst_delayed <= 1'b0;
        end else begin
            if (flush)
                flush_delayed <= 1'b1;
            else if (~icache_busy)
                flush_delayed <= 1'b0;
            if (refetch)
                refetch_delayed <= 1'b1;
            else if (~icache_busy)
                refetch_delayed <= 1'b0;
            if (icache_inst)
                icache_inst_delayed <= 1'b1;
            else if (~icache_busy)
                icache_inst_delayed <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (icache_inst)
            index_held <= icache_inst_index;
    end

    always_comb begin
        if (flush_delayed & ~icache_busy & ~br_flush & ~refetch_delayed)
            inst_valid = 1'b1;
        else if (ps_ex | itlb_stall)
            inst_valid = 1'b0;
        else
            inst_valid = ~icache_busy & fs_allowin & ~br_flush & ~refetch_delayed;
    end

    assign itlb_vpn    = pc[31:12];
    assign inst_tag    = itlb_pfn;
    assign inst_index  = icache_inst_delayed ? index_held : pc[11:4];
    assign inst_offset = pc[3:0];

    a_exc_code_matches_flag: assert property (
        @(posedge clk) disable iff (reset)
        (ps_exc == fetch_pkg::EXC_NONE) == !ps_ex
    );

endmodule

/* verilog/branch_stats.sv */
`timescale 1ns/1ps

module branch_stats #(
    parameter int COUNT_W = 32
) (
    input  logic               clk,
    input  logic               reset,
    br_if.sink                 br,
    output logic [COUNT_W-1:0] branch_count,
    output logic [COUNT_W-1:0] right_count
);

    logic right_hit;

    // only a checked prediction can be scored as right
    assign right_hit = br.is_branch & br.bpu_checked & br.bpu_right;

    always_ff @(posedge clk) begin
        if (reset) begin
            branch_count <= '0;
            right_count  <= '0;
        end else begin
            if (br.is_branch)
                branch_count <= branch_count + COUNT_W'(1);
            if (right_hit)
                right_count <= right_count + COUNT_W'(1);
        end
    end

    a_right_within_total: assert property (
        @(posedge clk) disable iff (reset)
        right_count <= branch_count
    );

endmodule

/* verilog/fetch_front.sv */
`timescale 1ns/1ps

module fetch_front #(
    parameter int COUNT_W = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     fs_allowin,
    input  logic                     br_bpu_checked,
    input  logic                     br_is_branch,
    input  logic                     br_taken,
    input  logic                     br_bpu_right,
    input  fetch_pkg::vaddr_t        br_target,
    input  fetch_pkg::vaddr_t        br_es_pc,
    input  logic                     bpu_valid,
    input  fetch_pkg::vaddr_t        bpu_target,
    input  logic                     br_flush,
    input  logic                     flush,
    input  logic                     flush_refill,
    input  logic                     eret,
    input  fetch_pkg::vaddr_t        epc,
    input  logic                     refetch,
    input  fetch_pkg::vaddr_t        refetch_pc,
    input  logic                     icache_inst,
    input  fetch_pkg::cache_index_t  icache_inst_index,
    input  logic                     icache_busy,
    output tlb_pkg::vpn_t            tlb_vpn,
    input  logic                     tlb_found,
    input  tlb_pkg::pfn_t            tlb_pfn0,
    input  tlb_pkg::pfn_t            tlb_pfn1,
    input  tlb_pkg::cache_attr_t     tlb_c0,
    input  tlb_pkg::cache_attr_t     tlb_c1,
    input  logic                     tlb_d0,
    input  logic                     tlb_d1,
    input  logic                     tlb_v0,
    input  logic                     tlb_v1,
    input  logic                     tlb_buffer_flush,
    output fetch_pkg::vaddr_t        pc,
    output logic                     ps_to_fs_valid,
    output logic                     inst_valid,
    output fetch_pkg::cache_index_t  inst_index,
    output tlb_pkg::pfn_t            inst_tag,
    output fetch_pkg::cache_offset_t inst_offset,
    output logic                     ps_ex,
    output fetch_pkg::exc_code_t     ps_exc,
    output logic                     icache_inst_delayed,
    output logic                     refill_miss,
    output logic [COUNT_W-1:0]       branch_count,
    output logic [COUNT_W-1:0]       right_count
);

    tlb_pkg::vpn_t        itlb_vpn;
    tlb_pkg::pfn_t        itlb_pfn;
    fetch_pkg::exc_code_t itlb_exc;
    logic                 itlb_ex;
    logic                 itlb_stall;

    br_if br ();

    assign br.bpu_checked = br_bpu_checked;
    assign br.is_branch   = br_is_branch;
    assign br.taken       = br_taken;
    assign br.bpu_right   = br_bpu_right;
    assign br.target      = br_target;
    assign br.es_pc       = br_es_pc;

    pre_if_stage u_pre_if (
        .clk                 (clk),
        .reset               (reset),
        .fs_allowin          (fs_allowin),
        .br                  (br.sink),
        .bpu_valid           (bpu_valid),
        .bpu_target          (bpu_target),
        .br_flush            (br_flush),
        .flush               (flush),
        .flush_refill        (flush_refill),
        .eret                (eret),
        .epc                 (epc),
        .refetch             (refetch),
        .refetch_pc          (refetch_pc),
        .icache_inst         (icache_inst),
        .icache_inst_index   (icache_inst_index),
        .icache_busy         (icache_busy),
        .itlb_vpn            (itlb_vpn),
        .itlb_pfn            (itlb_pfn),
        .itlb_ex             (itlb_ex),
        .itlb_exc            (itlb_exc),
        .itlb_stall          (itlb_stall),
        .pc                  (pc),
        .ps_to_fs_valid      (ps_to_fs_valid),
        .inst_valid          (inst_valid),
        .inst_index          (inst_index),
        .inst_tag            (inst_tag),
        .inst_offset         (inst_offset),
        .ps_ex               (ps_ex),
        .ps_exc              (ps_exc),
        .icache_inst_delayed (icache_inst_delayed)
    );

    itlb_stage u_itlb (
        .clk              (clk),
        .reset            (reset),
        .vpn              (itlb_vpn),
        .tlb_vpn          (tlb_vpn),
        .tlb_found        (tlb_found),
        .tlb_pfn0         (tlb_pfn0),
        .tlb_pfn1         (tlb_pfn1),
        .tlb_c0           (tlb_c0),
        .tlb_c1           (tlb_c1),
        .tlb_d0           (tlb_d0),
        .tlb_d1           (tlb_d1),
        .tlb_v0           (tlb_v0),
        .tlb_v1           (tlb_v1),
        .tlb_buffer_flush (tlb_buffer_flush),
        .pfn              (itlb_pfn),
        .itlb_ex          (itlb_ex),
        .itlb_exc         (itlb_exc),
        .refill_miss      (refill_miss),
        .itlb_stall       (itlb_stall)
    );

    branch_stats #(
        .COUNT_W (COUNT_W)
    ) u_stats (
        .clk          (clk),
        .reset        (reset),
        .br           (br.sink),
        .branch_count (branch_count),
        .right_count  (right_count)
    );

endmodule

/* testbench/fetch_front_tb.sv */
`timescale 1ns/1ps

module fetch_front_tb;

    localparam int COUNT_W = 32;

    // control flags of one table row
    localparam logic [12:0] F_NONE    = 13'h0000;
    localparam logic [12:0] F_BUSY    = 13'h0001;
    localparam logic [12:0] F_NOALLOW = 13'h0002;
    localparam logic [12:0] F_ERET    = 13'h0004;
    localparam logic [12:0] F_FLUSH   = 13'h0008;
    localparam logic [12:0] F_REFILL  = 13'h0010;
    localparam logic [12:0] F_REFETCH = 13'h0020;
    localparam logic [12:0] F_CACHEOP = 13'h0040;
    localparam logic [12:0] F_CHECKED = 13'h0080;
    localparam logic [12:0] F_BRANCH  = 13'h0100;
    localparam logic [12:0] F_TAKEN   = 13'h0200;
    localparam logic [12:0] F_RIGHT   = 13'h0400;
    localparam logic [12:0] F_BPU     = 13'h0800;
    localparam logic [12:0] F_RAND    = 13'h1000;

    // alt is epc, refetch_pc and the cache-op index at once
    typedef struct {
        logic [12:0]       ctl;
        fetch_pkg::vaddr_t target;
        fetch_pkg::vaddr_t es_pc;
        fetch_pkg::vaddr_t bpu;
        fetch_pkg::vaddr_t alt;
        fetch_pkg::vaddr_t exp;
    } row_t;

    logic clk, reset, fs_allowin, bpu_valid, br_flush, flush, flush_refill, eret;
    logic br_bpu_checked, br_is_branch, br_taken, br_bpu_right;
    logic refetch, icache_inst, icache_busy, tlb_found, tlb_buffer_flush;
    logic tlb_d0, tlb_d1, tlb_v0, tlb_v1;
    fetch_pkg::vaddr_t br_target, br_es_pc, bpu_target, epc, refetch_pc;
    fetch_pkg::cache_index_t icache_inst_index;
    tlb_pkg::pfn_t tlb_pfn0, tlb_pfn1;
    tlb_pkg::cache_attr_t tlb_c0, tlb_c1;
    tlb_pkg::vpn_t tlb_vpn;
    fetch_pkg::vaddr_t pc;
    logic ps_to_fs_valid, inst_valid, ps_ex, icache_inst_delayed, refill_miss;
    fetch_pkg::cache_index_t inst_index;
    tlb_pkg::pfn_t inst_tag;
    fetch_pkg::cache_offset_t inst_offset;
    fetch_pkg::exc_code_t ps_exc;
    logic [COUNT_W-1:0] branch_count, right_count;

    row_t rows[$];
    int errors = 0;
    int checks = 0;
    integer seed = 32'h8bf2_4769;
    logic cache_m;
    fetch_pkg::cache_index_t held_m;

    fetch_front #(.COUNT_W(COUNT_W)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // kernel pages map to themselves and one pair holds an invalid and a remapped page
    function automatic void map_lookup(input tlb_pkg::vpn_t vpn, output logic found,
                                       output logic valid, output tlb_pkg::pfn_t pfn);
        found = 1'b0;
        valid = 1'b0;
        pfn   = '0;
        if (vpn[19:16] == 4'hb) begin
            found = 1'b1;
            valid = 1'b1;
            pfn   = vpn;
        end else if (vpn == 20'h00400) begin
            found = 1'b1;
            pfn   = 20'h0aaa0;
        end else if (vpn == 20'h00401) begin
            found = 1'b1;
            valid = 1'b1;
            pfn   = 20'h12345;
        end
    endfunction

    // outside TLB answering the page requested one cycle earlier
    initial begin : tlb_responder
        tlb_pkg::vpn_t req_vpn;
        logic found0, found1;
        req_vpn   = '0;
        tlb_found = 1'b0;
        tlb_pfn0  = '0;
        tlb_pfn1  = '0;
        tlb_c0    = 3'd3;
        tlb_c1    = 3'd3;
        tlb_d0    = 1'b1;
        tlb_d1    = 1'b1;
        tlb_v0    = 1'b0;
        tlb_v1    = 1'b0;
        forever begin
            @(negedge clk);
            map_lookup({req_vpn[19:1], 1'b0}, found0, tlb_v0, tlb_pfn0);
            map_lookup({req_vpn[19:1], 1'b1}, found1, tlb_v1, tlb_pfn1);
            tlb_found = found0 | found1;
            req_vpn   = tlb_vpn;
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = rows.size() * 10 + 50;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        $display("test failed");
        $finish;
    end

    function automatic logic flag_on(input logic [12:0] ctl, input logic [12:0] f);
        return (ctl & f) != 13'd0;
    endfunction

    task automatic add_row(input logic [12:0] ctl, input fetch_pkg::vaddr_t target,
                           input fetch_pkg::vaddr_t es_pc, input fetch_pkg::vaddr_t bpu,
                           input fetch_pkg::vaddr_t alt, input fetch_pkg::vaddr_t exp);
        row_t r;
        r = '{ctl, target, es_pc, bpu, alt, exp};
        rows.push_back(r);
    endtask

    task automatic check_pc(input string name, input fetch_pkg::vaddr_t got,
                            input fetch_pkg::vaddr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_exc(input string name, input fetch_pkg::exc_code_t got,
                             input fetch_pkg::exc_code_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
                               input logic [COUNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_index(input string name, input fetch_pkg::cache_index_t got,
                               input fetch_pkg::cache_index_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input tlb_pkg::pfn_t got,
                             input tlb_pkg::pfn_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_vpn(input string name, input tlb_pkg::vpn_t got,
                             input tlb_pkg::vpn_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_offset(input string name, input fetch_pkg::cache_offset_t got,
                                input fetch_pkg::cache_offset_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wait_stall(output int cycles);
        cycles = 0;
        while (dut0.itlb_stall === 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (dut0.itlb_stall !== 1'b0) begin
            errors++;
            $display("itlb_stall never cleared, still high at %0t", $time);
        end
    endtask

    task automatic drive_row(input row_t r, input fetch_pkg::vaddr_t bpu);
        icache_busy       = flag_on(r.ctl, F_BUSY);
        fs_allowin        = !flag_on(r.ctl, F_NOALLOW);
        eret              = flag_on(r.ctl, F_ERET);
        flush             = flag_on(r.ctl, F_FLUSH);
        flush_refill      = flag_on(r.ctl, F_REFILL);
        refetch           = flag_on(r.ctl, F_REFETCH);
        icache_inst       = flag_on(r.ctl, F_CACHEOP);
        br_bpu_checked    = flag_on(r.ctl, F_CHECKED);
        br_is_branch      = flag_on(r.ctl, F_BRANCH);
        br_taken          = flag_on(r.ctl, F_TAKEN);
        br_bpu_right      = flag_on(r.ctl, F_RIGHT);
        bpu_valid         = flag_on(r.ctl, F_BPU);
        br_target         = r.target;
        br_es_pc          = r.es_pc;
        bpu_target        = bpu;
        epc               = r.alt;
        refetch_pc        = r.alt;
        icache_inst_index = r.alt[7:0];
    endtask

    // pulses drop and the PC is held while busy keeps its level
    task automatic drive_idle();
        fs_allowin     = 1'b0;
        eret           = 1'b0;
        flush          = 1'b0;
        flush_refill   = 1'b0;
        refetch        = 1'b0;
        icache_inst    = 1'b0;
        br_bpu_checked = 1'b0;
        br_is_branch   = 1'b0;
        br_taken       = 1'b0;
        br_bpu_right   = 1'b0;
        bpu_valid      = 1'b0;
    endtask

    task automatic check_fetch(input fetch_pkg::vaddr_t exp);
        logic found, valid;
        tlb_pkg::pfn_t pfn;
        fetch_pkg::exc_code_t exp_exc;
        map_lookup(exp[31:12], found, valid, pfn);
        if (exp[1:0] != 2'b00)
            exp_exc = fetch_pkg::EXC_ADEL;
        else if (!found || !valid)
            exp_exc = fetch_pkg::EXC_TLBL;
        else
            exp_exc = fetch_pkg::EXC_NONE;
        check_pc("pc", pc, exp);
        check_vpn("tlb_vpn", tlb_vpn, exp[31:12]);
        check_flag("ps_to_fs_valid", ps_to_fs_valid, !icache_busy);
        check_exc("ps_exc", ps_exc, exp_exc);
        check_flag("ps_ex", ps_ex, exp_exc != fetch_pkg::EXC_NONE);
        check_flag("refill_miss", refill_miss, !found);
        if (found && valid)
            check_tag("inst_tag", inst_tag, pfn);
        check_offset("inst_offset", inst_offset, exp[3:0]);
        check_index("inst_index", inst_index, cache_m ? held_m : exp[11:4]);
        check_flag("icache_inst_delayed", icache_inst_delayed, cache_m);
    endtask

    initial begin : main
        row_t r;
        fetch_pkg::vaddr_t cur;
        fetch_pkg::vaddr_t exp;
        fetch_pkg::vaddr_t bpu;
        int cycles;
        int n_branch;
        int n_right;
        reset            = 1'b1;
        br_flush         = 1'b0;
        tlb_buffer_flush = 1'b0;
        icache_busy      = 1'b0;
        br_target        = '0;
        br_es_pc         = '0;
        bpu_target       = '0;
        epc              = '0;
        refetch_pc       = '0;
        icache_inst_index = '0;
        drive_idle();
        cache_m  = 1'b0;
        held_m   = '0;
        n_branch = 0;
        n_right  = 0;

        // ctl, br target, es_pc, predictor target, alt, expected pc
        add_row(F_NONE, '0, '0, '0, '0, 32'hbfc0_0004);
        add_row(F_NONE, '0, '0, '0, '0, 32'hbfc0_0008);
        add_row(F_BPU, '0, '0, 32'hbfc0_0100, '0, 32'hbfc0_0100);
        add_row(F_BRANCH | F_TAKEN, 32'hbfc0_1000, '0, '0, '0, 32'hbfc0_1000);
        add_row(F_BRANCH, '0, '0, '0, '0, 32'hbfc0_1004);
        add_row(F_BRANCH | F_BPU, '0, '0, 32'hbfc0_1040, '0, 32'hbfc0_1040);
        add_row(F_BRANCH | F_CHECKED | F_RIGHT | F_BPU, '0, '0, 32'hbfc0_2000, '0,
                32'hbfc0_2000);
        add_row(F_BRANCH | F_CHECKED | F_RIGHT, '0, '0, '0, '0, 32'hbfc0_2004);
        add_row(F_BRANCH | F_CHECKED | F_TAKEN | F_BPU, 32'hbfc0_0040, '0, 32'hbfc0_3000, '0,
                32'hbfc0_0040);
        add_row(F_BRANCH | F_CHECKED, '0, 32'hbfc0_0030, '0, '0, 32'hbfc0_0038);
        add_row(F_BUSY | F_BPU, '0, '0, 32'hbfc0_0100, '0, 32'hbfc0_0038);
        add_row(F_NOALLOW, '0, '0, '0, '0, 32'hbfc0_0038);
        add_row(F_CACHEOP | F_BUSY, '0, '0, '0, 32'h0000_005a, 32'hbfc0_0038);
        add_row(F_BUSY, '0, '0, '0, '0, 32'hbfc0_0038);
        add_row(F_NONE, '0, '0, '0, '0, 32'hbfc0_003c);
        add_row(F_BPU | F_RAND, '0, '0, '0, '0, '0);
        add_row(F_BRANCH | F_CHECKED | F_RIGHT | F_BPU | F_RAND, '0, '0, '0, '0, '0);
        add_row(F_ERET | F_BRANCH | F_TAKEN, 32'hbfc0_3000, '0, '0, 32'hbfc0_0500,
                32'hbfc0_0500);
        add_row(F_FLUSH | F_BRANCH | F_TAKEN, 32'hbfc0_3000, '0, '0, '0, 32'hbfc0_0380);
        add_row(F_FLUSH | F_REFILL | F_BUSY, '0, '0, '0, '0, 32'hbfc0_0200);
        add_row(F_FLUSH | F_REFETCH, '0, '0, '0, 32'hbfc0_0600, 32'hbfc0_0600);
        add_row(F_ERET | F_FLUSH | F_REFILL, '0, '0, '0, 32'hbfc0_0700, 32'hbfc0_0700);
        add_row(F_ERET, '0, '0, '0, 32'hbfc0_0602, 32'hbfc0_0602);
        add_row(F_ERET, '0, '0, '0, 32'h0040_0000, 32'h0040_0000);
        add_row(F_ERET, '0, '0, '0, 32'h0040_1010, 32'h0040_1010);
        add_row(F_NONE, '0, '0, '0, '0, 32'h0040_1014);
        add_row(F_ERET, '0, '0, '0, 32'h0080_0000, 32'h0080_0000);
        add_row(F_ERET, '0, '0, '0, 32'h0080_0003, 32'h0080_0003);
        add_row(F_ERET, '0, '0, '0, 32'hbfc0_0000, 32'hbfc0_0000);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // nothing is offered until the first translation lands
        check_flag("ps_to_fs_valid", ps_to_fs_valid, 1'b0);
        check_flag("inst_valid", inst_valid, 1'b0);
        check_flag("icache_inst_delayed", icache_inst_delayed, 1'b0);
        wait_stall(cycles);
        cur = fetch_pkg::RESET_PC;
        check_fetch(cur);
        check_count("branch_count", branch_count, '0);
        check_count("right_count", right_count, '0);

        foreach (rows[i]) begin
            r   = rows[i];
            bpu = r.bpu;
            exp = r.exp;
            // both random cases resolve to the predictor target
            if (flag_on(r.ctl, F_RAND)) begin
                bpu = 32'hbfc0_0000 | ({$random(seed)} & 32'h0000_fffc);
                exp = bpu;
            end
            if (flag_on(r.ctl, F_BRANCH))
                n_branch++;
            if (flag_on(r.ctl, F_BRANCH | F_CHECKED | F_RIGHT) &&
                (r.ctl & (F_BRANCH | F_CHECKED | F_RIGHT)) == (F_BRANCH | F_CHECKED | F_RIGHT))
                n_right++;
            drive_row(r, bpu);
            #1;
            if (flag_on(r.ctl, F_BUSY | F_NOALLOW))
                check_flag("inst_valid", inst_valid, 1'b0);
            @(posedge clk);
            @(negedge clk);
            drive_idle();
            wait_stall(cycles);
            // a new page costs exactly two stall cycles
            checks++;
            if (cycles != ((exp[31:12] != cur[31:12]) ? 2 : 0)) begin
                errors++;
                $display("[FAIL] %0t itlb_stall cycles: got %0d, expected %0d", $time, cycles,
                         (exp[31:12] != cur[31:12]) ? 2 : 0);
            end
            if (flag_on(r.ctl, F_CACHEOP)) begin
                cache_m = 1'b1;
                held_m  = r.alt[7:0];
            end else if (!flag_on(r.ctl, F_BUSY)) begin
                cache_m = 1'b0;
            end
            check_fetch(exp);
            cur = exp;
        end

        check_count("branch_count", branch_count, COUNT_W'(n_branch));
        check_count("right_count", right_count, COUNT_W'(n_right));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* fetch_front.f */
common/fetch_pkg.sv
common/tlb_pkg.sv
common/br_if.sv
pre_if/itlb_stage.sv
pre_if/pre_if_stage.sv
verilog/branch_stats.sv
verilog/fetch_front.sv
testbench/fetch_front_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the fetch_front testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f fetch_front.f \
    --top-module fetch_front_tb -o fetch_front_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/fetch_front_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
exit 1
